//--- verilog.f
logic/rv_pkg.sv
logic/insn_mem.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/rv_core.sv
bench/core_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Mdir obj_dir --top-module core_tb -f verilog.f
	out="$$(./obj_dir/Vcore_tb)"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

//--- bench/core_tb.sv
module core_tb;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 5;
  localparam int RUN_LIMIT       = 3 * rv_pkg::IMEM_WORDS;
  localparam int NUM_TESTS       = 6;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (RESET_CYCLES + RUN_LIMIT + 20);

  logic              clk = 1'b0;
  logic              rst;
  logic              prog_we;
  rv_pkg::imem_idx_t prog_addr;
  rv_pkg::insn_t     prog_data;
  rv_pkg::retire_t   retire;
  rv_pkg::rf_write_t wb;
  logic              halt;

  rv_pkg::insn_t prog [rv_pkg::IMEM_WORDS];
  int            prog_len;
  int            errors;
  integer        seed;
  string         test_name;

  // expected retire stream, one entry per instruction in program order
  rv_pkg::addr_t    exp_pc [$];
  rv_pkg::insn_t    exp_insn [$];
  logic             exp_we [$];
  rv_pkg::reg_idx_t exp_rd [$];
  rv_pkg::word_t    exp_data [$];

  rv_core i_rv_core (
    .clk       (clk),
    .rst       (rst),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .retire    (retire),
    .wb        (wb),
    .halt      (halt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_word(string what, rv_pkg::word_t expected, rv_pkg::word_t actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_pc(string what, rv_pkg::addr_t expected, rv_pkg::addr_t actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_insn(string what, rv_pkg::insn_t expected, rv_pkg::insn_t actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_idx(string what, rv_pkg::reg_idx_t expected, rv_pkg::reg_idx_t actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s %s: expected x%0d, actual x%0d", test_name, what, expected, actual);
    end
  endtask

  task automatic check_bit(string what, logic expected, logic actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s %s: expected %b, actual %b", test_name, what, expected, actual);
    end
  endtask

  // instruction encoders
  function automatic rv_pkg::insn_t enc_r(logic [6:0] f7, rv_pkg::reg_idx_t rs2,
                                          rv_pkg::reg_idx_t rs1, logic [2:0] f3,
                                          rv_pkg::reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OPCODE_OP};
  endfunction

  function automatic rv_pkg::insn_t enc_i(logic [11:0] imm, rv_pkg::reg_idx_t rs1,
                                          logic [2:0] f3, rv_pkg::reg_idx_t rd,
                                          logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::insn_t enc_u(logic [19:0] imm, rv_pkg::reg_idx_t rd,
                                          logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic rv_pkg::insn_t enc_b(logic [12:0] off, rv_pkg::reg_idx_t rs1,
                                          rv_pkg::reg_idx_t rs2, logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPCODE_BRANCH};
  endfunction

  function automatic rv_pkg::insn_t enc_j(logic [20:0] off, rv_pkg::reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPCODE_JAL};
  endfunction

  task automatic clear_program(string name);
    test_name = name;
    prog_len  = 0;
    foreach (prog[i]) begin
      prog[i] = rv_pkg::INSN_ECALL;
    end
  endtask

  task automatic emit(rv_pkg::insn_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // reference semantics, RV32I spec
  function automatic rv_pkg::word_t model_alu(logic [2:0] f3, logic alt, rv_pkg::word_t a,
                                              rv_pkg::word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, rv_pkg::word_t a, rv_pkg::word_t b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // walks the program in order and fills the expected queues
  task automatic run_model();
    rv_pkg::word_t x [32];
    rv_pkg::addr_t pc;
    rv_pkg::addr_t next;
    rv_pkg::insn_t w;
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t res;
    logic          we;
    int            steps;
    exp_pc.delete();
    exp_insn.delete();
    exp_we.delete();
    exp_rd.delete();
    exp_data.delete();
    foreach (x[i]) begin
      x[i] = '0;
    end
    pc    = rv_pkg::RESET_PC;
    steps = 0;
    while (steps < RUN_LIMIT) begin
      w     = prog[pc[2 +: 8]];
      a     = x[w[19:15]];
      b     = x[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      next  = pc + 32'd4;
      we    = 1'b0;
      res   = '0;
      case (w[6:0])
        rv_pkg::OPCODE_OP: begin
          we  = 1'b1;
          res = model_alu(w[14:12], w[30], a, b);
        end
        rv_pkg::OPCODE_OP_IMM: begin
          we  = 1'b1;
          res = model_alu(w[14:12], w[30] && w[14:12] == 3'b101, a, imm_i);
        end
        rv_pkg::OPCODE_LUI: begin
          we  = 1'b1;
          res = {w[31:12], 12'b0};
        end
        rv_pkg::OPCODE_AUIPC: begin
          we  = 1'b1;
          res = pc + {w[31:12], 12'b0};
        end
        rv_pkg::OPCODE_JAL: begin
          we   = 1'b1;
          res  = pc + 32'd4;
          next = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        rv_pkg::OPCODE_JALR: begin
          we   = 1'b1;
          res  = pc + 32'd4;
          next = (a + imm_i) & ~32'd1;
        end
        rv_pkg::OPCODE_BRANCH: begin
          if (branch_taken(w[14:12], a, b)) begin
            next = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        default: ;
      endcase
      exp_pc.push_back(pc);
      exp_insn.push_back(w);
      exp_we.push_back(we && w[11:7] != 5'd0);
      exp_rd.push_back(w[11:7]);
      exp_data.push_back(res);
      if (we && w[11:7] != 5'd0) begin
        x[w[11:7]] = res;
      end
      if (w == rv_pkg::INSN_ECALL) begin
        break;
      end
      pc = next;
      steps++;
    end
  endtask

  // load under reset, release, then follow retirements until halt
  task automatic run_program();
    int   cycles;
    int   idx;
    logic halt_due;
    logic done;
    run_model();
    @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < rv_pkg::IMEM_WORDS; i++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= rv_pkg::imem_idx_t'(i);
      prog_data <= prog[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_bit("retire valid in reset", 1'b0, retire.valid);
      check_bit("wb we in reset", 1'b0, wb.we);
      check_bit("halt in reset", 1'b0, halt);
    end
    @(posedge clk);
    rst <= 1'b0;
    cycles   = 0;
    idx      = 0;
    halt_due = 1'b0;
    done     = 1'b0;
    while (!done && cycles < RUN_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (halt_due) begin
        check_bit("halt after ecall", 1'b1, halt);
        done = 1'b1;
      end else begin
        check_bit("halt before ecall", 1'b0, halt);
        if (!retire.valid) begin
          check_bit("wb we without retire", 1'b0, wb.we);
        end else if (idx >= exp_pc.size()) begin
          errors++;
          $display("%s: the core retired more instructions than the program", test_name);
        end else begin
          if (idx == 0) begin
            check_pc("first retired pc", rv_pkg::RESET_PC, retire.pc);
          end
          check_pc("retired pc", exp_pc[idx], retire.pc);
          check_insn("retired insn", exp_insn[idx], retire.insn);
          check_bit("wb we", exp_we[idx], wb.we);
          if (exp_we[idx]) begin
            check_idx("wb rd", exp_rd[idx], wb.rd);
            check_word("wb data", exp_data[idx], wb.data);
          end
          halt_due = (idx == exp_pc.size() - 1);
          idx++;
        end
      end
    end
    if (!done) begin
      errors++;
      $display("%s: the core did not halt within %0d cycles", test_name, RUN_LIMIT);
    end
    // pipeline keeps running behind the halt
    repeat (10) begin
      if (retire.valid || wb.we) begin
        errors++;
        $display("%s: an instruction retired after halt", test_name);
      end
      @(negedge clk);
    end
  endtask

  task automatic emit_rand_imm(logic [2:0] f3, rv_pkg::reg_idx_t rd);
    logic [31:0] r;
    r = $random(seed);
    emit(enc_i(r[11:0], 5'd2, f3, rd, rv_pkg::OPCODE_OP_IMM));
  endtask

  task automatic test_imm_ops();
    logic [31:0] r;
    clear_program("imm_ops");
    r = $random(seed);
    emit(enc_u(r[31:12], 5'd1, rv_pkg::OPCODE_LUI));
    r = $random(seed);
    emit(enc_i(r[11:0], 5'd1, 3'b000, 5'd2, rv_pkg::OPCODE_OP_IMM));
    emit_rand_imm(3'b010, 5'd3);
    emit_rand_imm(3'b011, 5'd4);
    emit_rand_imm(3'b100, 5'd5);
    emit_rand_imm(3'b110, 5'd6);
    emit_rand_imm(3'b111, 5'd7);
    r = $random(seed);
    emit(enc_i({7'b0000000, r[4:0]}, 5'd2, 3'b001, 5'd8, rv_pkg::OPCODE_OP_IMM));
    emit(enc_i({7'b0000000, r[9:5]}, 5'd2, 3'b101, 5'd9, rv_pkg::OPCODE_OP_IMM));
    emit(enc_i({7'b0100000, r[14:10]}, 5'd2, 3'b101, 5'd10, rv_pkg::OPCODE_OP_IMM));
    emit(enc_u(r[31:12], 5'd11, rv_pkg::OPCODE_AUIPC));
    run_program();
  endtask

  // rd reads the two results just before it
  task automatic emit_chain(logic [6:0] f7, logic [2:0] f3, rv_pkg::reg_idx_t rd);
    emit(enc_r(f7, rd - 5'd2, rd - 5'd1, f3, rd));
  endtask

  task automatic test_reg_ops();
    logic [31:0] r;
    clear_program("reg_ops");
    r = $random(seed);
    emit(enc_u(r[31:12], 5'd1, rv_pkg::OPCODE_LUI));
    emit(enc_i(r[11:0], 5'd1, 3'b000, 5'd1, rv_pkg::OPCODE_OP_IMM));
    r = $random(seed);
    emit(enc_u(r[31:12], 5'd2, rv_pkg::OPCODE_LUI));
    emit(enc_i(r[11:0], 5'd2, 3'b000, 5'd2, rv_pkg::OPCODE_OP_IMM));
    emit_chain(7'h00, 3'b000, 5'd3);
    emit_chain(7'h20, 3'b000, 5'd4);
    emit_chain(7'h00, 3'b001, 5'd5);
    emit_chain(7'h00, 3'b010, 5'd6);
    emit_chain(7'h00, 3'b011, 5'd7);
    emit_chain(7'h00, 3'b100, 5'd8);
    emit_chain(7'h00, 3'b101, 5'd9);
    emit_chain(7'h20, 3'b101, 5'd10);
    emit_chain(7'h00, 3'b110, 5'd11);
    emit_chain(7'h00, 3'b111, 5'd12);
    run_program();
  endtask

  // a taken branch skips the two counters and lands on the third
  task automatic emit_branch(logic [2:0] f3, rv_pkg::reg_idx_t rs1, rv_pkg::reg_idx_t rs2);
    emit(enc_b(13'd12, rs1, rs2, f3));
    emit(enc_i(12'd1, 5'd10, 3'b000, 5'd10, rv_pkg::OPCODE_OP_IMM));
    emit(enc_i(12'd1, 5'd11, 3'b000, 5'd11, rv_pkg::OPCODE_OP_IMM));
    emit(enc_i(12'd1, 5'd12, 3'b000, 5'd12, rv_pkg::OPCODE_OP_IMM));
  endtask

  task automatic test_branches();
    clear_program("branches");
    emit(enc_i(12'd5, 5'd0, 3'b000, 5'd1, rv_pkg::OPCODE_OP_IMM));
    emit(enc_i(12'hffd, 5'd0, 3'b000, 5'd2, rv_pkg::OPCODE_OP_IMM));
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        emit_branch(3'(f), 5'd1, 5'd2);
        emit_branch(3'(f), 5'd2, 5'd1);
        emit_branch(3'(f), 5'd1, 5'd1);
      end
    end
    run_program();
  endtask

  task automatic test_jumps();
    clear_program("jumps");
    emit(enc_i(12'd7, 5'd0, 3'b000, 5'd1, rv_pkg::OPCODE_OP_IMM));
    emit(enc_j(21'd12, 5'd5));
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd6, rv_pkg::OPCODE_OP_IMM));
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd7, rv_pkg::OPCODE_OP_IMM));
    emit(enc_i(12'd0, 5'd5, 3'b000, 5'd8, rv_pkg::OPCODE_OP_IMM));
    emit(enc_u(20'd0, 5'd9, rv_pkg::OPCODE_AUIPC));
    // odd offset, target drops bit 0
    emit(enc_i(12'd13, 5'd9, 3'b000, 5'd10, rv_pkg::OPCODE_JALR));
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd6, rv_pkg::OPCODE_OP_IMM));
    emit(enc_i(12'd1, 5'd10, 3'b000, 5'd11, rv_pkg::OPCODE_OP_IMM));
    emit(enc_j(21'd8, 5'd0));
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd7, rv_pkg::OPCODE_OP_IMM));
    emit(enc_i(12'd3, 5'd11, 3'b000, 5'd12, rv_pkg::OPCODE_OP_IMM));
    run_program();
  endtask

  task automatic test_x0();
    clear_program("x0");
    emit(enc_i(12'd123, 5'd0, 3'b000, 5'd0, rv_pkg::OPCODE_OP_IMM));
    emit(enc_i(12'h7ff, 5'd0, 3'b110, 5'd1, rv_pkg::OPCODE_OP_IMM));
    emit(enc_u(20'habcde, 5'd0, rv_pkg::OPCODE_LUI));
    emit(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd2));
    emit(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd0));
    emit(enc_r(7'h00, 5'd0, 5'd1, 3'b000, 5'd3));
    // unknown opcode writes nothing
    emit(32'h0000_150b);
    emit(enc_r(7'h00, 5'd3, 5'd0, 3'b000, 5'd4));
    run_program();
  endtask

  task automatic test_reset_halt();
    clear_program("reset_halt");
    emit(enc_i(12'd1, 5'd0, 3'b000, 5'd1, rv_pkg::OPCODE_OP_IMM));
    emit(rv_pkg::INSN_ECALL);
    emit(enc_i(12'd2, 5'd0, 3'b000, 5'd2, rv_pkg::OPCODE_OP_IMM));
    emit(enc_i(12'd3, 5'd0, 3'b000, 5'd3, rv_pkg::OPCODE_OP_IMM));
    run_program();
  endtask

  initial begin
    rst       = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    errors    = 0;
    seed      = 32'h9c57_16a0;
    test_imm_ops();
    test_reg_ops();
    test_branches();
    test_jumps();
    test_x0();
    test_reset_halt();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, errors: %0d", WATCHDOG_CYCLES, errors);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- logic/rv_core.sv
module rv_core (
  input  logic              clk,
  input  logic              rst,
  input  logic              prog_we,
  input  rv_pkg::imem_idx_t prog_addr,
  input  rv_pkg::insn_t     prog_data,
  output rv_pkg::retire_t   retire,
  output rv_pkg::rf_write_t wb,
  output logic              halt
);

  rv_pkg::imem_idx_t imem_idx;
  rv_pkg::insn_t     imem_insn;
  rv_pkg::fetch_t    fetch;
  rv_pkg::redirect_t redirect;
  rv_pkg::exec_t     exec;
  rv_pkg::result_t   result;

  insn_mem i_insn_mem (
    .clk       (clk),
    .rst       (rst),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .rd_idx    (imem_idx),
    .insn      (imem_insn)
  );

  fetch_unit i_fetch_unit (
    .clk       (clk),
    .rst       (rst),
    .redirect  (redirect),
    .imem_idx  (imem_idx),
    .imem_insn (imem_insn),
    .fetch     (fetch)
  );

  decode_stage i_decode_stage (
    .clk      (clk),
    .rst      (rst),
    .fetch    (fetch),
    .redirect (redirect),
    .wr       (wb),
    .exec     (exec)
  );

  // the register write doubles as the bypass source
  execute_stage i_execute_stage (
    .clk      (clk),
    .rst      (rst),
    .exec     (exec),
    .bypass   (wb),
    .redirect (redirect),
    .result   (result)
  );

  result_stage i_result_stage (
    .clk    (clk),
    .rst    (rst),
    .result (result),
    .wr     (wb),
    .retire (retire),
    .halt   (halt)
  );

endmodule

//--- logic/result_stage.sv
module result_stage (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::result_t   result,
  output rv_pkg::rf_write_t wr,
  output rv_pkg::retire_t   retire,
  output logic              halt
);

  logic halted;
  logic live;

  // nothing retires once the core has halted
  assign live = result.valid && !halted;

  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
    end else if (live && result.halt) begin
      halted <= 1'b1;
    end
  end

  assign wr.we       = live && result.rd_we && (result.rd != '0);
  assign wr.rd       = result.rd;
  assign wr.data     = result.data;

  assign retire.valid = live;
  assign retire.pc    = result.pc;
  assign retire.insn  = result.insn;

  assign halt = halted;

  // ecall comes out of decode with no register write
  a_halt_writes_nothing : assert property (@(posedge clk) disable iff (rst)
    result.valid && result.halt |-> !result.rd_we);

endmodule

//--- logic/execute_stage.sv
module execute_stage (
  input  logic               clk,
  input  logic               rst,
  input  rv_pkg::exec_t      exec,
  input  rv_pkg::rf_write_t  bypass,
  output rv_pkg::redirect_t  redirect,
  output rv_pkg::result_t    result
);

  rv_pkg::word_t   op_a;
  rv_pkg::word_t   rs2_val;
  rv_pkg::word_t   op_b;
  rv_pkg::word_t   alu_out;
  rv_pkg::word_t   res_data;
  rv_pkg::addr_t   link;
  logic            br_cond;
  logic            taken;
  rv_pkg::result_t result_d;

  // we already excludes x0, so a match is enough
  assign op_a    = (bypass.we && bypass.rd == exec.rs1) ? bypass.data : exec.rs1_data;
  assign rs2_val = (bypass.we && bypass.rd == exec.rs2) ? bypass.data : exec.rs2_data;
  assign op_b    = exec.use_imm ? exec.imm : rs2_val;

  always_comb begin
    case (exec.alu_op)
      rv_pkg::ALU_ADD:  alu_out = op_a + op_b;
      rv_pkg::ALU_SUB:  alu_out = op_a - op_b;
      rv_pkg::ALU_SLL:  alu_out = op_a << op_b[4:0];
      rv_pkg::ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU: alu_out = {31'b0, op_a < op_b};
      rv_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
      rv_pkg::ALU_SRL:  alu_out = op_a >> op_b[4:0];
      rv_pkg::ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
      rv_pkg::ALU_OR:   alu_out = op_a | op_b;
      rv_pkg::ALU_AND:  alu_out = op_a & op_b;
      default:          alu_out = op_b;
    endcase
  end

  // branch compare on the register operands
  always_comb begin
    case (exec.br_funct3)
      3'b000:  br_cond = (op_a == rs2_val);
      3'b001:  br_cond = (op_a != rs2_val);
      3'b100:  br_cond = $signed(op_a) < $signed(rs2_val);
      3'b101:  br_cond = $signed(op_a) >= $signed(rs2_val);
      3'b110:  br_cond = op_a < rs2_val;
      3'b111:  br_cond = op_a >= rs2_val;
      default: br_cond = 1'b0;
    endcase
  end

  assign link  = exec.pc + 32'd4;
  assign taken = exec.is_jal || exec.is_jalr || (exec.is_branch && br_cond);

  always_comb begin
    if (exec.is_jal || exec.is_jalr) begin
      res_data = link;
    end else if (exec.is_auipc) begin
      res_data = exec.pc + exec.imm;
    end else begin
      res_data = alu_out;
    end
  end

  // branches and jal are pc relative, jalr drops bit 0
  assign redirect.valid  = exec.valid && taken;
  assign redirect.target = exec.is_jalr ? ((op_a + exec.imm) & ~32'd1)
                                        : exec.pc + exec.imm;

  always_comb begin
    result_d.valid = exec.valid;
    result_d.pc    = exec.pc;
    result_d.insn  = exec.insn;
    result_d.rd    = exec.rd;
    result_d.rd_we = exec.rd_we;
    result_d.data  = res_data;
    result_d.halt  = exec.is_halt;
  end

  always_ff @(posedge clk) begin
    result <= result_d;
    if (rst) begin
      result.valid <= 1'b0;
    end
  end

endmodule

//--- logic/decode_stage.sv
module decode_stage (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::fetch_t    fetch,
  input  rv_pkg::redirect_t redirect,
  input  rv_pkg::rf_write_t wr,
  output rv_pkg::exec_t     exec
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::word_t    imm_i;
  rv_pkg::word_t    imm_u;
  rv_pkg::word_t    imm_b;
  rv_pkg::word_t    imm_j;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::alu_op_e  alu_op;
  rv_pkg::exec_t    exec_d;

  assign {funct7, rs2, rs1, funct3, rd, opcode} = fetch.insn;

  assign imm_i = {{20{fetch.insn[31]}}, fetch.insn[31:20]};
  assign imm_u = {fetch.insn[31:12], 12'b0};
  assign imm_b = {{20{fetch.insn[31]}}, fetch.insn[7], fetch.insn[30:25],
                  fetch.insn[11:8], 1'b0};
  assign imm_j = {{12{fetch.insn[31]}}, fetch.insn[19:12], fetch.insn[20],
                  fetch.insn[30:21], 1'b0};

  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (wr)
  );

  // shared by op and op-imm; sub only exists in the register form
  always_comb begin
    case (funct3)
      3'b000:  alu_op = (opcode == rv_pkg::OPCODE_OP && funct7[5]) ? rv_pkg::ALU_SUB
                                                                  : rv_pkg::ALU_ADD;
      3'b001:  alu_op = rv_pkg::ALU_SLL;
      3'b010:  alu_op = rv_pkg::ALU_SLT;
      3'b011:  alu_op = rv_pkg::ALU_SLTU;
      3'b100:  alu_op = rv_pkg::ALU_XOR;
      3'b101:  alu_op = funct7[5] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  alu_op = rv_pkg::ALU_OR;
      default: alu_op = rv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    exec_d           = '0;
    exec_d.valid     = fetch.valid;
    exec_d.pc        = fetch.pc;
    exec_d.insn      = fetch.insn;
    exec_d.alu_op    = alu_op;
    exec_d.rs1       = rs1;
    exec_d.rs2       = rs2;
    exec_d.rs1_data  = rs1_data;
    exec_d.rs2_data  = rs2_data;
    exec_d.rd        = rd;
    exec_d.br_funct3 = funct3;
    case (opcode)
      rv_pkg::OPCODE_OP: begin
        exec_d.rd_we = 1'b1;
      end
      rv_pkg::OPCODE_OP_IMM: begin
        exec_d.rd_we   = 1'b1;
        exec_d.use_imm = 1'b1;
        exec_d.imm     = imm_i;
      end
      rv_pkg::OPCODE_LUI: begin
        exec_d.rd_we   = 1'b1;
        exec_d.use_imm = 1'b1;
        exec_d.imm     = imm_u;
        exec_d.alu_op  = rv_pkg::ALU_PASS_IMM;
      end
      rv_pkg::OPCODE_AUIPC: begin
        exec_d.rd_we    = 1'b1;
        exec_d.is_auipc = 1'b1;
        exec_d.imm      = imm_u;
      end
      rv_pkg::OPCODE_JAL: begin
        exec_d.rd_we  = 1'b1;
        exec_d.is_jal = 1'b1;
        exec_d.imm    = imm_j;
      end
      rv_pkg::OPCODE_JALR: begin
        exec_d.rd_we   = 1'b1;
        exec_d.is_jalr = 1'b1;
        exec_d.imm     = imm_i;
      end
      rv_pkg::OPCODE_BRANCH: begin
        exec_d.is_branch = 1'b1;
        exec_d.imm       = imm_b;
      end
      rv_pkg::OPCODE_SYSTEM: begin
        exec_d.is_halt = (fetch.insn == rv_pkg::INSN_ECALL);
      end
      // unknown opcodes pass through and write nothing
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    exec <= exec_d;
    if (rst || redirect.valid) begin
      exec.valid <= 1'b0;
    end
  end

endmodule

//--- logic/reg_file.sv
module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_idx_t  rs1,
  input  rv_pkg::reg_idx_t  rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  rv_pkg::rf_write_t wr
);

  rv_pkg::word_t regs [1:31];

  function automatic rv_pkg::word_t read_reg(rv_pkg::reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end
    // same-cycle write goes straight through
    if (wr.we && wr.rd == idx) begin
      return wr.data;
    end
    return regs[idx];
  endfunction

  always_comb begin
    rs1_data = read_reg(rs1);
    rs2_data = read_reg(rs2);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.we && wr.rd != '0) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // result stage filters x0 writes before they get here
  a_no_x0_write : assert property (@(posedge clk) disable iff (rst) wr.we |-> wr.rd != '0);

endmodule

//--- logic/fetch_unit.sv
module fetch_unit (
  input  logic               clk,
  input  logic               rst,
  input  rv_pkg::redirect_t  redirect,
  output rv_pkg::imem_idx_t  imem_idx,
  input  rv_pkg::insn_t      imem_insn,
  output rv_pkg::fetch_t     fetch
);

  rv_pkg::addr_t pc;
  rv_pkg::addr_t pc_q;
  logic          valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= rv_pkg::RESET_PC;
      valid_q <= 1'b0;
    end else begin
      pc      <= redirect.valid ? redirect.target : pc + 32'd4;
      // the word read at a redirect edge is on the wrong path
      valid_q <= !redirect.valid;
    end
    pc_q <= pc;
  end

  assign imem_idx = pc[2 +: $bits(rv_pkg::imem_idx_t)];

  // pc_q lines up with the memory output
  assign fetch = '{valid: valid_q, pc: pc_q, insn: imem_insn};

  a_pc_aligned : assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

//--- logic/insn_mem.sv
module insn_mem (
  input  logic              clk,
  input  logic              rst,
  input  logic              prog_we,
  input  rv_pkg::imem_idx_t prog_addr,
  input  rv_pkg::insn_t     prog_data,
  input  rv_pkg::imem_idx_t rd_idx,
  output rv_pkg::insn_t     insn
);

  rv_pkg::insn_t mem [rv_pkg::IMEM_WORDS];

  // program port and registered read share the one clock
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
    insn <= mem[rd_idx];
  end

  // loading only while the core is held in reset
  a_prog_in_reset : assert property (@(posedge clk) prog_we |-> rst);

endmodule

//--- logic/rv_pkg.sv
package rv_pkg;

  // data path widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0] reg_idx_t;

  // instruction memory geometry
  localparam int IMEM_WORDS = 256;
  typedef logic [$clog2(IMEM_WORDS)-1:0] imem_idx_t;

  localparam addr_t RESET_PC = 32'h0000_0000;

  // major opcodes
  localparam logic [6:0] OPCODE_OP     = 7'b01_100_11;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b00_100_11;
  localparam logic [6:0] OPCODE_LUI    = 7'b01_101_11;
  localparam logic [6:0] OPCODE_AUIPC  = 7'b00_101_11;
  localparam logic [6:0] OPCODE_JAL    = 7'b11_011_11;
  localparam logic [6:0] OPCODE_JALR   = 7'b11_001_11;
  localparam logic [6:0] OPCODE_BRANCH = 7'b11_000_11;
  localparam logic [6:0] OPCODE_SYSTEM = 7'b11_100_11;

  localparam insn_t INSN_ECALL = 32'h0000_0073;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_IMM
  } alu_op_e;

  // fetch to decode
  typedef struct packed {
    logic  valid;
    addr_t pc;
    insn_t insn;
  } fetch_t;

  // decode to execute
  typedef struct packed {
    logic       valid;
    addr_t      pc;
    insn_t      insn;
    alu_op_e    alu_op;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm;
    reg_idx_t   rd;
    logic       rd_we;
    logic       use_imm;
    logic       is_auipc;
    logic       is_branch;
    logic [2:0] br_funct3;
    logic       is_jal;
    logic       is_jalr;
    logic       is_halt;
  } exec_t;

  // execute to result
  typedef struct packed {
    logic     valid;
    addr_t    pc;
    insn_t    insn;
    reg_idx_t rd;
    logic     rd_we;
    word_t    data;
    logic     halt;
  } result_t;

  typedef struct packed {
    logic     we;
    reg_idx_t rd;
    word_t    data;
  } rf_write_t;

  typedef struct packed {
    logic  valid;
    addr_t target;
  } redirect_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;
    insn_t insn;
  } retire_t;

endpackage
